/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

  localparam int word_width = 16;
  localparam int pc_width = 8;
  localparam int addr_width = 8;

  // Sixteen data stack entries, two of which live in the top registers
  localparam int dstack_depth = 16;
  localparam int cstack_depth = 4;
  localparam int lstack_depth = 4;

  typedef logic [word_width-1:0] word_t;
  typedef logic [pc_width-1:0] pc_t;
  typedef logic [addr_width-1:0] addr_t;

  // Values not listed here decode as a no-op
  typedef enum logic [6:0] {
    op_nop   = 7'h00,
    op_add   = 7'h01,
    op_addc  = 7'h02,
    op_sub   = 7'h03,
    op_and   = 7'h04,
    op_xor   = 7'h05,
    op_dup   = 7'h06,
    op_drop  = 7'h07,
    op_swap  = 7'h08,
    op_load  = 7'h09,
    op_store = 7'h0a,
    op_jz    = 7'h0b,
    op_call  = 7'h0c,
    op_ret   = 7'h0d,
    op_loop  = 7'h0e,
    op_halt  = 7'h0f
  } opcode_e;

  typedef struct packed {
    logic is_lit;
    logic [6:0] value;
  } lit_view_t;

  typedef struct packed {
    logic is_lit;
    opcode_e opcode;
  } op_view_t;

  // The instruction byte pushes its low seven bits when the top bit is set
  typedef union packed {
    lit_view_t lit;
    op_view_t op;
  } instr_u;

  typedef struct packed {
    word_t top;
    word_t second;
  } stack_view_t;

  // One loop level as it is held while active and while saved
  typedef struct packed {
    pc_t beginning;
    pc_t ending;
    word_t total;
    word_t index;
  } loop_frame_t;

endpackage

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  input  logic              carry_in,
  input  core_pkg::opcode_e opcode,
  output core_pkg::word_t   result,
  output logic              carry_out
);
  import core_pkg::*;

  word_t b_operand;
  logic add_carry;
  logic [word_width:0] sum;

  // Subtract is a plus the inverted b with a forced carry in
  always_comb begin
    b_operand = b;
    add_carry = 1'b0;
    case (opcode)
      op_addc: add_carry = carry_in;
      op_sub: begin
        b_operand = ~b;
        add_carry = 1'b1;
      end
      default: ;
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, b_operand} + {{word_width{1'b0}}, add_carry};
  assign carry_out = sum[word_width];

  always_comb begin
    case (opcode)
      op_add, op_addc, op_sub: result = sum[word_width-1:0];
      op_and: result = a & b;
      op_xor: result = a ^ b;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/lifo_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module lifo_stack #(
  parameter int width = 8,
  parameter int depth = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic             pop,
  input  logic [width-1:0] insert,
  output logic [width-1:0] top,
  output logic             empty
);

  logic [width-1:0] entries [depth];
  logic [$clog2(depth+1)-1:0] count;
  logic [$clog2(depth)-1:0] free_slot;
  logic [$clog2(depth)-1:0] top_slot;
  logic full;

  assign free_slot = count[$clog2(depth)-1:0];
  assign top_slot = free_slot - 1'b1;
  assign top = entries[top_slot];
  assign empty = count == '0;
  assign full = int'(count) == depth;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end

  // Push and pop together swap out the top entry
  always_ff @(posedge clk) begin
    if (push && pop) begin
      entries[top_slot] <= insert;
    end else if (push) begin
      entries[free_slot] <= insert;
    end
  end

  no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

  no_overflow: assert property (@(posedge clk) disable iff (reset) push && !pop |-> !full);

endmodule

`default_nettype wire

/* verilog/data_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module data_stack (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push,
  input  logic                  pop,
  input  logic                  replace_top,
  input  logic                  pop_two,
  input  core_pkg::word_t       next_top,
  input  core_pkg::word_t       next_second,
  output core_pkg::stack_view_t view
);
  import core_pkg::*;

  // Entries below the top two
  word_t rest [dstack_depth - 2];
  logic [$clog2(dstack_depth):0] depth;
  logic [$clog2(dstack_depth):0] depth_less_two;
  logic [$clog2(dstack_depth)-1:0] slot;
  logic [$clog2(dstack_depth)-1:0] slot_m1;
  logic [$clog2(dstack_depth)-1:0] slot_m2;

  // slot is the next free entry of rest
  assign depth_less_two = depth - 2'd2;
  assign slot = depth_less_two[$clog2(dstack_depth)-1:0];
  assign slot_m1 = slot - 1'b1;
  assign slot_m2 = slot - 2'd2;

  always_ff @(posedge clk) begin
    if (reset) begin
      depth <= '0;
    end else if (push) begin
      depth <= depth + 1'b1;
    end else if (pop) begin
      depth <= depth - 1'b1;
    end else if (pop_two) begin
      depth <= depth - 2'd2;
    end
  end

  // A pop also loads a new top, which makes binary ops a single step
  always_ff @(posedge clk) begin
    if (push) begin
      view.top <= next_top;
      view.second <= view.top;
      if (depth > 1'b1) begin
        rest[slot] <= view.second;
      end
    end else if (pop) begin
      view.top <= next_top;
      view.second <= rest[slot_m1];
    end else if (pop_two) begin
      view.top <= rest[slot_m1];
      view.second <= rest[slot_m2];
    end else if (replace_top) begin
      view.top <= next_top;
      view.second <= next_second;
    end
  end

  no_overflow: assert property (
    @(posedge clk) disable iff (reset) push |-> int'(depth) < dstack_depth
  );

  no_underflow: assert property (
    @(posedge clk) disable iff (reset) (pop |-> depth != '0) and (pop_two |-> depth > 1'b1)
  );

endmodule

`default_nettype wire

/* verilog/stack_control.sv */
`timescale 1ns/1ps
`default_nettype none

module stack_control (
  input  logic                  clk,
  input  logic                  reset,
  input  core_pkg::instr_u      instr,
  input  core_pkg::word_t       mainmem_read_value,
  output core_pkg::stack_view_t view,
  output logic                  stall,
  output core_pkg::addr_t       mainmem_addr,
  output core_pkg::word_t       mainmem_write_value,
  output logic                  mainmem_we
);
  import core_pkg::*;

  logic is_op;
  logic is_load;
  logic is_store;
  logic load_phase;
  logic carry;
  logic carry_we;
  logic push;
  logic pop;
  logic replace_top;
  logic pop_two;
  word_t next_top;
  word_t next_second;
  word_t alu_result;
  logic alu_carry;

  assign is_op = !instr.op.is_lit;
  assign is_load = is_op && instr.op.opcode == op_load;
  assign is_store = is_op && instr.op.opcode == op_store;

  // First cycle of a load only presents the address
  assign stall = is_load && !load_phase;

  // Loads and stores both take their address from the top entry
  assign mainmem_addr = view.top[addr_width-1:0];
  assign mainmem_write_value = view.second;
  // No instruction executes while reset is held
  assign mainmem_we = is_store && !reset;

  always_comb begin
    push = 1'b0;
    pop = 1'b0;
    replace_top = 1'b0;
    pop_two = 1'b0;
    carry_we = 1'b0;
    next_top = view.second;
    next_second = view.second;
    if (!is_op) begin
      push = 1'b1;
      next_top = {{(word_width - 7){1'b0}}, instr.lit.value};
    end else begin
      case (instr.op.opcode)
        op_add, op_addc, op_sub: begin
          pop = 1'b1;
          carry_we = 1'b1;
          next_top = alu_result;
        end
        op_and, op_xor: begin
          pop = 1'b1;
          next_top = alu_result;
        end
        op_dup: begin
          push = 1'b1;
          next_top = view.top;
        end
        op_drop, op_call: pop = 1'b1;
        op_swap: begin
          replace_top = 1'b1;
          next_second = view.top;
        end
        op_load: begin
          // Read data is valid in the second cycle
          replace_top = load_phase;
          next_top = mainmem_read_value;
        end
        op_store, op_jz, op_loop: pop_two = 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      load_phase <= 1'b0;
      carry <= 1'b0;
    end else begin
      load_phase <= stall;
      if (carry_we) begin
        carry <= alu_carry;
      end
    end
  end

  alu alu_inst (
    .a(view.second),
    .b(view.top),
    .carry_in(carry),
    .opcode(instr.op.opcode),
    .result(alu_result),
    .carry_out(alu_carry)
  );

  data_stack data_stack_inst (
    .clk,
    .reset,
    .push,
    .pop,
    .replace_top,
    .pop_two,
    .next_top,
    .next_second,
    .view
  );

  // A load always finishes in its second cycle and never writes memory there
  load_completes: assert property (
    @(posedge clk) disable iff (reset) stall |=> !stall && !mainmem_we
  );

endmodule

`default_nettype wire

/* verilog/fetch_control.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_control (
  input  logic                  clk,
  input  logic                  reset,
  input  core_pkg::instr_u      instr,
  input  core_pkg::stack_view_t view,
  input  logic                  stall,
  input  logic                  loop_jump,
  input  core_pkg::pc_t         loop_target,
  output core_pkg::pc_t         pc,
  output core_pkg::pc_t         programmem_addr,
  output logic                  halted
);
  import core_pkg::*;

  pc_t pc_next;
  pc_t pc_plus_one;
  pc_t return_addr;
  logic is_op;
  logic halt_op;
  logic call_op;
  logic ret_op;
  logic jz_taken;
  logic hold;

  assign is_op = !instr.op.is_lit;
  assign halt_op = is_op && instr.op.opcode == op_halt;
  assign call_op = is_op && instr.op.opcode == op_call;
  assign ret_op = is_op && instr.op.opcode == op_ret;
  assign jz_taken = is_op && instr.op.opcode == op_jz && view.second == '0;

  // A halt holds its own address so the same byte keeps coming back
  assign hold = stall || halted || halt_op;

  assign pc_plus_one = pc + 1'b1;

  // Program memory is addressed with the next pc, so fetch runs without a bubble
  always_comb begin
    if (reset) begin
      pc_next = '0;
    end else if (hold) begin
      pc_next = pc;
    end else if (jz_taken || call_op) begin
      pc_next = view.top[pc_width-1:0];
    end else if (ret_op) begin
      pc_next = return_addr;
    end else if (loop_jump) begin
      pc_next = loop_target;
    end else begin
      pc_next = pc_plus_one;
    end
  end

  assign programmem_addr = pc_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      halted <= 1'b0;
    end else begin
      pc <= pc_next;
      if (halt_op) begin
        halted <= 1'b1;
      end
    end
  end

  // Return addresses for nested calls
  lifo_stack #(
    .width(pc_width),
    .depth(cstack_depth)
  ) call_stack (
    .clk,
    .reset,
    .push(call_op),
    .pop(ret_op),
    .insert(pc_plus_one),
    .top(return_addr),
    .empty()
  );

  // Once halted the held address keeps returning the halt byte until the next reset
  halt_stays_fetched: assert property (
    @(posedge clk) disable iff (reset) halted |-> halt_op
  );

endmodule

`default_nettype wire

/* verilog/loop_control.sv */
`timescale 1ns/1ps
`default_nettype none

module loop_control (
  input  logic                  clk,
  input  logic                  reset,
  input  core_pkg::instr_u      instr,
  input  core_pkg::stack_view_t view,
  input  core_pkg::pc_t         pc,
  input  logic                  stall,
  output logic                  loop_jump,
  output core_pkg::pc_t         loop_target
);
  import core_pkg::*;

  loop_frame_t frame;
  loop_frame_t new_frame;
  loop_frame_t saved;
  word_t index_next;
  logic active;
  logic start;
  logic at_end;
  logic step;
  logic last;
  logic lstack_empty;

  assign start = !instr.op.is_lit && instr.op.opcode == op_loop;

  // Body runs from the byte after the loop instruction to the end address inclusive
  assign new_frame.beginning = pc + 1'b1;
  assign new_frame.ending = view.top[pc_width-1:0];
  assign new_frame.total = view.second;
  assign new_frame.index = '0;

  assign at_end = active && pc == frame.ending;
  assign step = at_end && !stall;
  assign index_next = frame.index + 1'b1;
  // A count of zero still makes one pass
  assign last = index_next >= frame.total;

  assign loop_jump = at_end && !last;
  assign loop_target = frame.beginning;

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
    end else if (start) begin
      active <= 1'b1;
    end else if (step && last && lstack_empty) begin
      active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      frame <= new_frame;
    end else if (step) begin
      if (!last) begin
        frame.index <= index_next;
      end else if (!lstack_empty) begin
        // Outer loop picks up where it left off
        frame <= saved;
      end
    end
  end

  // Outer loops wait here while an inner loop runs
  lifo_stack #(
    .width($bits(loop_frame_t)),
    .depth(lstack_depth)
  ) loop_stack (
    .clk,
    .reset,
    .push(start && active),
    .pop(step && last && !lstack_empty),
    .insert(frame),
    .top(saved),
    .empty(lstack_empty)
  );

endmodule

`default_nettype wire

/* verilog/core0.sv */
`timescale 1ns/1ps
`default_nettype none

module core0 (
  input  logic              clk,
  input  logic              reset,

  // Program memory, read data arrives one cycle after the address
  output core_pkg::pc_t     programmem_addr,
  input  core_pkg::instr_u  programmem_read_value,

  // Main memory, shared address for reads and writes
  output core_pkg::addr_t   mainmem_addr,
  input  core_pkg::word_t   mainmem_read_value,
  output core_pkg::word_t   mainmem_write_value,
  output logic              mainmem_we,

  output logic              halted
);
  import core_pkg::*;

  stack_view_t view;
  pc_t pc;
  pc_t loop_target;
  logic stall;
  logic loop_jump;

  fetch_control fetch_control_inst (
    .clk,
    .reset,
    .instr(programmem_read_value),
    .view,
    .stall,
    .loop_jump,
    .loop_target,
    .pc,
    .programmem_addr,
    .halted
  );

  stack_control stack_control_inst (
    .clk,
    .reset,
    .instr(programmem_read_value),
    .mainmem_read_value,
    .view,
    .stall,
    .mainmem_addr,
    .mainmem_write_value,
    .mainmem_we
  );

  loop_control loop_control_inst (
    .clk,
    .reset,
    .instr(programmem_read_value),
    .view,
    .pc,
    .stall,
    .loop_jump,
    .loop_target
  );

endmodule

`default_nettype wire

/* bench/core0_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core0_tb;
  import core_pkg::*;

  localparam int num_programs = 8;
  localparam int main_limit = 52;
  localparam int sub_base0 = 100;
  localparam int sub_base1 = 114;
  localparam int max_depth = 8;
  localparam int halt_timeout = 6000;

  logic clk;
  logic reset;
  instr_u programmem_read_value;
  word_t mainmem_read_value;
  pc_t programmem_addr;
  addr_t mainmem_addr;
  word_t mainmem_write_value;
  logic mainmem_we;
  logic halted;

  logic [7:0] prog [256];
  word_t main_mem [256];
  word_t model_mem [256];
  logic [7:0] exp_addr [$];
  word_t exp_data [$];
  pc_t halt_addr;
  integer seed;
  int errors;
  int writes_seen;
  int programs_run;
  int pos;
  int gen_depth;
  logic abort;

  core0 core0_inst (
    .clk,
    .reset,
    .programmem_addr,
    .programmem_read_value,
    .mainmem_addr,
    .mainmem_read_value,
    .mainmem_write_value,
    .mainmem_we,
    .halted
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Both memories answer one cycle after the address, and every write is checked in order
  always @(posedge clk) begin : memories
    logic [7:0] ea;
    word_t ed;
    programmem_read_value <= prog[programmem_addr];
    mainmem_read_value <= main_mem[mainmem_addr];
    if (mainmem_we) begin
      main_mem[mainmem_addr] = mainmem_write_value;
      writes_seen++;
      if (exp_addr.size() == 0) begin
        errors++;
        $display("Main memory was written more often than the model expects");
      end else begin
        ea = exp_addr.pop_front();
        ed = exp_data.pop_front();
        if (mainmem_addr != ea) begin
          errors++;
          $display("Fail mainmem_addr: got %h, expected %h", mainmem_addr, ea);
        end
        if (mainmem_write_value != ed) begin
          errors++;
          $display("Fail mainmem_write_value: got %h, expected %h", mainmem_write_value, ed);
        end
      end
    end
  end

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [7:0] lit_byte(int v);
    return {1'b1, v[6:0]};
  endfunction

  function automatic logic [7:0] op_byte(opcode_e o);
    return {1'b0, o};
  endfunction

  task automatic emit(input logic [7:0] b);
    prog[pos] = b;
    pos++;
  endtask

  // Every piece leaves the stack depth as it found it and writes one word
  task automatic store_piece(input bit allow_dup);
    case (rand_below(allow_dup ? 3 : 2))
      0: begin
        emit(lit_byte(rand_below(128)));
        emit(lit_byte(rand_below(32)));
      end
      1: begin
        emit(lit_byte(rand_below(32)));
        emit(op_byte(op_load));
        emit(lit_byte(rand_below(32)));
      end
      default: begin
        emit(op_byte(op_dup));
        emit(lit_byte(rand_below(32)));
      end
    endcase
    emit(op_byte(op_store));
  endtask

  task automatic open_loop(output int end_slot);
    emit(lit_byte(rand_below(4)));
    end_slot = pos;
    emit(lit_byte(0));
    emit(op_byte(op_loop));
  endtask

  // The body always closes with a store, so inner and outer ends never coincide
  task automatic close_loop(input int end_slot);
    store_piece(gen_depth >= 1);
    prog[end_slot] = lit_byte(pos - 1);
  endtask

  task automatic inner_loop();
    int end_slot;
    int items;
    open_loop(end_slot);
    items = rand_below(2);
    repeat (items) store_piece(gen_depth >= 1);
    close_loop(end_slot);
  endtask

  task automatic outer_loop();
    int end_slot;
    int items;
    open_loop(end_slot);
    items = rand_below(3);
    repeat (items) begin
      if (rand_below(2) == 0) begin
        inner_loop();
      end else begin
        store_piece(gen_depth >= 1);
      end
    end
    close_loop(end_slot);
  endtask

  task automatic binary_op();
    case (rand_below(5))
      0: emit(op_byte(op_add));
      1: emit(op_byte(op_addc));
      2: emit(op_byte(op_sub));
      3: emit(op_byte(op_and));
      default: emit(op_byte(op_xor));
    endcase
    gen_depth--;
  endtask

  task automatic gen_piece();
    int kind;
    int slot;
    kind = rand_below(8);
    if (gen_depth < 2 && kind <= 2) kind = 3;
    case (kind)
      0, 1: binary_op();
      2: begin
        case (rand_below(3))
          0: begin
            emit(op_byte(gen_depth < max_depth ? op_dup : op_drop));
            gen_depth += (gen_depth < max_depth) ? 1 : -1;
          end
          1: begin
            emit(op_byte(op_drop));
            gen_depth--;
          end
          default: emit(op_byte(op_swap));
        endcase
      end
      3: begin
        if (gen_depth < max_depth) begin
          emit(lit_byte(rand_below(128)));
          gen_depth++;
        end else begin
          binary_op();
        end
      end
      4: store_piece(gen_depth >= 1);
      5: begin
        // Condition below the target, and a store that only runs when not taken
        emit(lit_byte(rand_below(2) == 0 ? 0 : 1 + rand_below(127)));
        slot = pos;
        emit(lit_byte(0));
        emit(op_byte(op_jz));
        store_piece(gen_depth >= 1);
        prog[slot] = lit_byte(pos);
      end
      6: begin
        emit(lit_byte(rand_below(2) == 0 ? sub_base0 : sub_base1));
        emit(op_byte(op_call));
      end
      default: outer_loop();
    endcase
  endtask

  task automatic sub_body();
    int items;
    items = 1 + rand_below(3);
    repeat (items) store_piece(1'b0);
    emit(op_byte(op_ret));
  endtask

  task automatic build_program();
    int i;
    for (i = 0; i < 256; i++) begin
      prog[i] = op_byte(op_nop);
      main_mem[i] = {8'(i) ^ 8'h5a, 8'(i)};
      model_mem[i] = {8'(i) ^ 8'h5a, 8'(i)};
    end
    pos = 0;
    gen_depth = 0;
    while (pos < main_limit) gen_piece();
    i = 0;
    while (gen_depth > 0) begin
      emit(lit_byte(32 + i));
      emit(op_byte(op_store));
      gen_depth--;
      i++;
    end
    emit(op_byte(op_halt));
    pos = sub_base0;
    sub_body();
    pos = sub_base1;
    sub_body();
  endtask

  // Reference interpreter that lists every expected write in order
  task automatic run_model();
    word_t st [16];
    pc_t cs [4];
    int lbeg [4];
    int lend [4];
    int ltot [4];
    int lidx [4];
    int sp;
    int csp;
    int lsp;
    int steps;
    int beg;
    int en;
    int tot;
    int idx;
    pc_t pc;
    pc_t q;
    logic active;
    logic carry;
    logic done;
    logic check_end;
    logic [7:0] b;
    logic [16:0] wide;
    word_t a;
    word_t t;
    sp = 0;
    csp = 0;
    lsp = 0;
    steps = 0;
    beg = 0;
    en = 0;
    tot = 0;
    idx = 0;
    pc = '0;
    active = 1'b0;
    carry = 1'b0;
    done = 1'b0;
    while (!done && steps < 5000) begin
      b = prog[pc];
      q = pc;
      pc = pc + 1'b1;
      check_end = 1'b1;
      steps++;
      a = (sp >= 2) ? st[sp-2] : '0;
      t = (sp >= 1) ? st[sp-1] : '0;
      if (b[7]) begin
        st[sp] = {9'b0, b[6:0]};
        sp++;
      end else begin
        case (opcode_e'(b[6:0]))
          op_add, op_addc, op_sub: begin
            if (opcode_e'(b[6:0]) == op_sub) begin
              wide = {1'b0, a} + {1'b0, ~t} + 17'd1;
            end else if (opcode_e'(b[6:0]) == op_addc) begin
              wide = {1'b0, a} + {1'b0, t} + {16'b0, carry};
            end else begin
              wide = {1'b0, a} + {1'b0, t};
            end
            carry = wide[16];
            sp--;
            st[sp-1] = wide[15:0];
          end
          op_and: begin
            sp--;
            st[sp-1] = a & t;
          end
          op_xor: begin
            sp--;
            st[sp-1] = a ^ t;
          end
          op_dup: begin
            st[sp] = t;
            sp++;
          end
          op_drop: sp--;
          op_swap: begin
            st[sp-1] = a;
            st[sp-2] = t;
          end
          op_load: st[sp-1] = model_mem[t[7:0]];
          op_store: begin
            model_mem[t[7:0]] = a;
            exp_addr.push_back(t[7:0]);
            exp_data.push_back(a);
            sp -= 2;
          end
          op_jz: begin
            sp -= 2;
            if (a == '0) begin
              pc = t[7:0];
              check_end = 1'b0;
            end
          end
          op_call: begin
            cs[csp] = q + 1'b1;
            csp++;
            pc = t[7:0];
            sp--;
            check_end = 1'b0;
          end
          op_ret: begin
            csp--;
            pc = cs[csp];
            check_end = 1'b0;
          end
          op_loop: begin
            if (active) begin
              lbeg[lsp] = beg;
              lend[lsp] = en;
              ltot[lsp] = tot;
              lidx[lsp] = idx;
              lsp++;
            end
            beg = int'(q) + 1;
            en = int'(t[7:0]);
            tot = int'(a);
            idx = 0;
            active = 1'b1;
            sp -= 2;
            check_end = 1'b0;
          end
          op_halt: begin
            done = 1'b1;
            halt_addr = q;
            check_end = 1'b0;
          end
          default: ;
        endcase
      end
      if (check_end && active && int'(q) == en) begin
        if (idx + 1 >= tot) begin
          if (lsp > 0) begin
            lsp--;
            beg = lbeg[lsp];
            en = lend[lsp];
            tot = ltot[lsp];
            idx = lidx[lsp];
          end else begin
            active = 1'b0;
          end
        end else begin
          idx++;
          pc = pc_t'(beg);
        end
      end
    end
    if (!done) begin
      errors++;
      $display("The reference model did not reach a halt instruction");
    end
  endtask

  task automatic apply_reset();
    int cycle;
    reset <= 1'b1;
    for (cycle = 0; cycle < 10; cycle++) begin
      @(posedge clk);
      if (programmem_addr != '0) begin
        errors++;
        $display("Fail programmem_addr: got %h, expected %h", programmem_addr, 8'h00);
      end
      if (mainmem_we) begin
        errors++;
        $display("Fail mainmem_we: got %h, expected %h", mainmem_we, 1'b0);
      end
      // The halted flag of the previous program only clears at the first edge in reset
      if (cycle > 0 && halted !== 1'b0) begin
        errors++;
        $display("Fail halted: got %h, expected %h", halted, 1'b0);
      end
    end
    reset <= 1'b0;
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!halted && cycles < halt_timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      errors++;
      abort = 1'b1;
      $display("Timed out waiting for the core to halt");
    end
  endtask

  task automatic check_halt_holds();
    repeat (50) begin
      @(posedge clk);
      if (!halted) begin
        errors++;
        $display("Fail halted: got %h, expected %h", halted, 1'b1);
      end
      if (programmem_addr != halt_addr) begin
        errors++;
        $display("Fail programmem_addr: got %h, expected %h", programmem_addr, halt_addr);
      end
    end
  endtask

  initial begin
    seed = 62;
    errors = 0;
    writes_seen = 0;
    programs_run = 0;
    abort = 1'b0;
    reset <= 1'b1;
    programmem_read_value <= '0;
    mainmem_read_value <= '0;
    while (programs_run < num_programs && !abort) begin
      exp_addr.delete();
      exp_data.delete();
      build_program();
      run_model();
      apply_reset();
      wait_for_halt();
      if (!abort) begin
        check_halt_holds();
        if (exp_addr.size() != 0) begin
          errors++;
          $display("%0d expected writes never reached main memory", exp_addr.size());
        end
      end
      programs_run++;
    end
    $display("Programs run %0d, writes checked %0d, errors %0d", programs_run, writes_seen,
             errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
verilog/core_pkg.sv
verilog/alu.sv
verilog/lifo_stack.sv
verilog/data_stack.sv
verilog/stack_control.sv
verilog/fetch_control.sv
verilog/loop_control.sv
verilog/core0.sv
bench/core0_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= core0_tb
OBJ_DIR ?= obj_dir
FILELIST ?= src.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q '^Testbench passed$$'

clean:
	rm -rf $(OBJ_DIR)
